// File: logic/portal_macros.svh
`ifndef PORTAL_MACROS_SVH
`define PORTAL_MACROS_SVH

`define DATA_W 32
`define AXI_ID_W 12
`define ID_W 6           // Upper id bits return as zero
`define LEN_W 4
`define OFFS_W 5
`define BEAT_STRIDE 4

`define PAGE_LSB 5
`define PAGE_MSB 11      // Page zero is the control page
`define SEL_BIT 12       // Indication half when set

`define CTRL_IRQ_OFFS 0
`define CTRL_IEN_OFFS 4
`define CTRL_ONE_OFFS 8
`define CTRL_IRQ2_OFFS 12
`define CTRL_KIND_OFFS 16
`define CTRL_TWO_OFFS 20
`define KIND_REQ 5
`define KIND_IND 6

`define USER_VAL_OFFS 0
`define USER_RDY_OFFS 4

`define WUSE_CTRL 2'd0
`define WUSE_USER 2'd1
`define WUSE_DROP 2'd2   // Indication half of the user page
`endif

// File: logic/portalPkg.sv
`include "portal_macros.svh"

package portalPkg;

  // One write word, seen whole by the user or as a control register
  typedef union packed {
    logic [`DATA_W-1:0] user;
    struct packed {
      logic [`DATA_W-2:0] reserved;
      logic intEnable;
    } ctrl;
  } portalWordT;

endpackage

// File: logic/stageFifo.sv
`timescale 1ns/10ps

module stageFifo #(
  parameter int Width = 32
) (
  input  logic             CLK,
  input  logic             nRST,
  input  logic             enqValid,
  input  logic [Width-1:0] enqData,
  output logic             enqReady,
  input  logic             deqTake,
  output logic             deqValid,
  output logic [Width-1:0] deqData
);

  logic full;
  logic [Width-1:0] data;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      full <= 1'b0;
    end else if (enqValid && !full) begin
      full <= 1'b1;
    end else if (deqTake && full) begin
      full <= 1'b0;
    end
  end

  always_ff @(posedge CLK) begin
    if (enqValid && !full) begin
      data <= enqData;
    end
  end

  assign enqReady = !full;
  assign deqValid = full;
  assign deqData  = data;

endmodule

// File: logic/burstSplitter.sv
`timescale 1ns/10ps
`include "portal_macros.svh"

module burstSplitter (
  input  logic              CLK,
  input  logic              nRST,
  input  logic              reqValid,
  input  logic [`OFFS_W-1:0] reqOffs,
  input  logic [`ID_W-1:0]  reqId,
  input  logic [`LEN_W-1:0] reqLen,
  output logic              reqReady,
  input  logic              beatTake,
  output logic              beatValid,
  output logic [`OFFS_W-1:0] beatOffs,
  output logic [`ID_W-1:0]  beatId,
  output logic              beatLast
);

  localparam int ReqW  = `OFFS_W + `LEN_W + `ID_W;
  localparam int BeatW = `OFFS_W + `ID_W + 1;

  logic [ReqW-1:0] heldReq;
  logic [BeatW-1:0] beatWord;
  logic heldValid;
  logic [`OFFS_W-1:0] offs;
  logic [`OFFS_W-1:0] curOffs;
  logic [`LEN_W:0] count;        // One extra bit for len of 15
  logic [`LEN_W:0] curCount;
  logic notFirst;
  logic curLast;
  logic beatRoom;
  logic genBeat;

  stageFifo #(.Width(ReqW)) reqBuf (
    .CLK(CLK), .nRST(nRST),
    .enqValid(reqValid), .enqData({reqOffs, reqLen, reqId}), .enqReady(reqReady),
    .deqTake(genBeat && curLast), .deqValid(heldValid), .deqData(heldReq)
  );

  assign curOffs  = notFirst ? offs : heldReq[ReqW-1 -: `OFFS_W];
  assign curCount = notFirst ? count : {1'b0, heldReq[`ID_W +: `LEN_W]} + 1'b1;
  assign curLast  = curCount == 1;
  assign genBeat  = heldValid && beatRoom;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      offs     <= '0;
      count    <= '0;
      notFirst <= 1'b0;
    end else if (genBeat) begin
      offs     <= curOffs + `OFFS_W'(`BEAT_STRIDE);  // Wraps in 5 bits
      count    <= curCount - 1'b1;
      notFirst <= !curLast;
    end
  end

  stageFifo #(.Width(BeatW)) beatBuf (
    .CLK(CLK), .nRST(nRST),
    .enqValid(genBeat), .enqData({curOffs, heldReq[`ID_W-1:0], curLast}),
    .enqReady(beatRoom),
    .deqTake(beatTake), .deqValid(beatValid), .deqData(beatWord)
  );

  assign {beatOffs, beatId, beatLast} = beatWord;

endmodule

// File: logic/portalControl.sv
`timescale 1ns/10ps
`include "portal_macros.svh"

module portalControl (
  input  logic                          CLK,
  input  logic                          nRST,
  input  logic                          arFire,
  input  logic [`SEL_BIT:`PAGE_LSB]     arAddr,
  input  logic                          awFire,
  input  logic [`SEL_BIT:`PAGE_LSB]     awAddr,
  input  logic [`OFFS_W-1:0]            readOffs,
  input  logic                          pending,
  input  logic                          writeReady,
  input  logic                          writeBeatFire,
  input  logic [`OFFS_W-1:0]            writeOffs,
  input  portalPkg::portalWordT         writeWord,
  output logic                          readIsCtrl,
  output logic [`DATA_W-1:0]            ctrlValue,
  output logic [1:0]                    writeUse,
  output logic                          interrupt
);

  logic readCtrl;
  logic readSel;
  logic writeCtrl;
  logic writeSel;
  logic intEnable;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      readCtrl  <= 1'b0;
      readSel   <= 1'b0;
      writeCtrl <= 1'b0;
      writeSel  <= 1'b0;
      intEnable <= 1'b0;
    end else begin
      if (arFire) begin
        readCtrl <= arAddr[`PAGE_MSB:`PAGE_LSB] == '0;
        readSel  <= arAddr[`SEL_BIT];
      end
      if (awFire) begin
        writeCtrl <= awAddr[`PAGE_MSB:`PAGE_LSB] == '0;
        writeSel  <= awAddr[`SEL_BIT];
      end
      if (writeBeatFire && writeUse == `WUSE_CTRL && writeOffs == `OFFS_W'(`CTRL_IEN_OFFS)) begin
        intEnable <= writeWord.ctrl.intEnable;
      end
    end
  end

  always_comb begin
    ctrlValue = '0;
    if (readCtrl) begin
      case (readOffs)
        `OFFS_W'(`CTRL_IRQ_OFFS), `OFFS_W'(`CTRL_IRQ2_OFFS): ctrlValue[0] = pending && !readSel;
        `OFFS_W'(`CTRL_ONE_OFFS):  ctrlValue = `DATA_W'(1);
        `OFFS_W'(`CTRL_KIND_OFFS): ctrlValue = readSel ? `DATA_W'(`KIND_IND) : `DATA_W'(`KIND_REQ);
        `OFFS_W'(`CTRL_TWO_OFFS):  ctrlValue = `DATA_W'(2);
        default:                   ctrlValue = '0;
      endcase
    end else if (readOffs == `OFFS_W'(`USER_RDY_OFFS)) begin
      ctrlValue[0] = writeReady;  // Endpoint empty
    end
  end

  always_comb begin
    if (writeCtrl) begin
      writeUse = `WUSE_CTRL;
    end else if (writeSel) begin
      writeUse = `WUSE_DROP;
    end else begin
      writeUse = `WUSE_USER;
    end
  end

  assign readIsCtrl = readCtrl;
  assign interrupt  = pending && intEnable;

endmodule

// File: logic/echoUser.sv
`timescale 1ns/10ps
`include "portal_macros.svh"

module echoUser (
  input  logic                  CLK,
  input  logic                  nRST,
  input  logic                  writeStrobe,
  input  portalPkg::portalWordT writeWord,
  output logic                  writeReady,
  input  logic                  consume,
  output logic                  pending,
  output logic [`DATA_W-1:0]    value
);

  logic [`DATA_W-1:0] held;

  always_ff @(posedge CLK) begin
    if (!nRST) begin
      pending <= 1'b0;
    end else if (writeStrobe && !pending) begin
      pending <= 1'b1;
    end else if (consume) begin
      pending <= 1'b0;   // Read of the indication
    end
  end

  always_ff @(posedge CLK) begin
    if (writeStrobe && !pending) begin
      held <= writeWord.user;
    end
  end

  assign writeReady = !pending;
  assign value      = pending ? held : '0;

endmodule

// File: logic/portalBridge.sv
`timescale 1ns/10ps
`include "portal_macros.svh"

module portalBridge (
  input  logic                 CLK,
  input  logic                 nRST,
  input  logic                 arValid,
  input  logic [`DATA_W-1:0]   arAddr,
  input  logic [`AXI_ID_W-1:0] arId,
  input  logic [`LEN_W-1:0]    arLen,
  output logic                 arReady,
  input  logic                 awValid,
  input  logic [`DATA_W-1:0]   awAddr,
  input  logic [`AXI_ID_W-1:0] awId,
  input  logic [`LEN_W-1:0]    awLen,
  output logic                 awReady,
  input  logic                 wValid,
  input  logic [`DATA_W-1:0]   wData,
  output logic                 wReady,
  output logic                 rValid,
  output logic [`DATA_W-1:0]   rData,
  output logic [`AXI_ID_W-1:0] rId,
  output logic                 rLast,
  input  logic                 rReady,
  output logic                 bValid,
  output logic [`AXI_ID_W-1:0] bId,
  input  logic                 bReady,
  output logic                 interrupt
);

  localparam int ReadW = `DATA_W + `ID_W + 1;

  logic arReqReady;
  logic awReqReady;
  logic readBeatValid;
  logic [`OFFS_W-1:0] readBeatOffs;
  logic [`ID_W-1:0] readBeatId;
  logic readBeatLast;
  logic writeBeatValid;
  logic [`OFFS_W-1:0] writeBeatOffs;
  logic [`ID_W-1:0] writeBeatId;
  logic writeBeatLast;
  logic readRoom;
  logic doneRoom;
  logic wordHeld;
  portalPkg::portalWordT writeWord;
  logic [ReadW-1:0] readWord;
  logic [`ID_W-1:0] rIdLow;
  logic [`ID_W-1:0] bIdLow;
  logic readIsCtrl;
  logic [`DATA_W-1:0] ctrlValue;
  logic [`DATA_W-1:0] readValue;
  logic [1:0] writeUse;
  logic userReady;
  logic userPending;
  logic [`DATA_W-1:0] userValue;
  logic readUserWord;
  logic readTake;
  logic writeTake;

  // New requests wait until the previous burst's beats have left
  assign arReady = arReqReady && !readBeatValid;
  assign awReady = awReqReady && !writeBeatValid;

  assign readTake  = readBeatValid && readRoom;
  assign writeTake = writeBeatValid && wordHeld && (!writeBeatLast || doneRoom) &&
                     (writeUse != `WUSE_USER || userReady);

  burstSplitter readSplit (
    .CLK(CLK), .nRST(nRST),
    .reqValid(arValid && !readBeatValid), .reqOffs(arAddr[`OFFS_W-1:0]),
    .reqId(arId[`ID_W-1:0]), .reqLen(arLen), .reqReady(arReqReady),
    .beatTake(readTake), .beatValid(readBeatValid), .beatOffs(readBeatOffs),
    .beatId(readBeatId), .beatLast(readBeatLast)
  );

  burstSplitter writeSplit (
    .CLK(CLK), .nRST(nRST),
    .reqValid(awValid && !writeBeatValid), .reqOffs(awAddr[`OFFS_W-1:0]),
    .reqId(awId[`ID_W-1:0]), .reqLen(awLen), .reqReady(awReqReady),
    .beatTake(writeTake), .beatValid(writeBeatValid), .beatOffs(writeBeatOffs),
    .beatId(writeBeatId), .beatLast(writeBeatLast)
  );

  assign readUserWord = !readIsCtrl && readBeatOffs == `OFFS_W'(`USER_VAL_OFFS);
  assign readValue    = readUserWord ? userValue : ctrlValue;

  stageFifo #(.Width(ReadW)) readData (
    .CLK(CLK), .nRST(nRST),
    .enqValid(readTake), .enqData({readValue, readBeatId, readBeatLast}), .enqReady(readRoom),
    .deqTake(rValid && rReady), .deqValid(rValid), .deqData(readWord)
  );

  assign {rData, rIdLow, rLast} = readWord;
  assign rId = {{(`AXI_ID_W - `ID_W){1'b0}}, rIdLow};

  stageFifo #(.Width(`DATA_W)) writeData (
    .CLK(CLK), .nRST(nRST),
    .enqValid(wValid), .enqData(wData), .enqReady(wReady),
    .deqTake(writeTake), .deqValid(wordHeld), .deqData(writeWord)
  );

  stageFifo #(.Width(`ID_W)) writeDone (
    .CLK(CLK), .nRST(nRST),
    .enqValid(writeTake && writeBeatLast), .enqData(writeBeatId), .enqReady(doneRoom),
    .deqTake(bValid && bReady), .deqValid(bValid), .deqData(bIdLow)
  );

  assign bId = {{(`AXI_ID_W - `ID_W){1'b0}}, bIdLow};

  portalControl control (
    .CLK(CLK), .nRST(nRST),
    .arFire(arValid && arReady), .arAddr(arAddr[`SEL_BIT:`PAGE_LSB]),
    .awFire(awValid && awReady), .awAddr(awAddr[`SEL_BIT:`PAGE_LSB]),
    .readOffs(readBeatOffs), .pending(userPending), .writeReady(userReady),
    .writeBeatFire(writeTake), .writeOffs(writeBeatOffs), .writeWord(writeWord),
    .readIsCtrl(readIsCtrl), .ctrlValue(ctrlValue), .writeUse(writeUse),
    .interrupt(interrupt)
  );

  echoUser user (
    .CLK(CLK), .nRST(nRST),
    .writeStrobe(writeTake && writeUse == `WUSE_USER), .writeWord(writeWord),
    .writeReady(userReady),
    .consume(readTake && readUserWord), .pending(userPending), .value(userValue)
  );

endmodule

// File: sim/portalBridgeTb.sv
`timescale 1ns/10ps
`include "portal_macros.svh"

module portalBridgeTb;

  localparam int TimeoutCycles = 4000;  // Roughly twice the longest run

  logic CLK;
  logic nRST;
  logic arValid;
  logic [31:0] arAddr;
  logic [11:0] arId;
  logic [3:0] arLen;
  logic arReady;
  logic awValid;
  logic [31:0] awAddr;
  logic [11:0] awId;
  logic [3:0] awLen;
  logic awReady;
  logic wValid;
  logic [31:0] wData;
  logic wReady;
  logic rValid;
  logic [31:0] rData;
  logic [11:0] rId;
  logic rLast;
  logic rReady;
  logic bValid;
  logic [11:0] bId;
  logic bReady;
  logic interrupt;

  logic [31:0] stimState;
  logic [31:0] readyState;
  logic [2:0] holdLeft;
  logic pressure;
  logic modelPend;
  logic modelIen;
  logic [31:0] modelWord;
  logic [31:0] expData[$];
  logic [11:0] expRId[$];
  logic expLast[$];
  logic [11:0] expBId[$];
  int cycles;

  portalBridge portalBridge_i (
    .CLK(CLK), .nRST(nRST),
    .arValid(arValid), .arAddr(arAddr), .arId(arId), .arLen(arLen), .arReady(arReady),
    .awValid(awValid), .awAddr(awAddr), .awId(awId), .awLen(awLen), .awReady(awReady),
    .wValid(wValid), .wData(wData), .wReady(wReady),
    .rValid(rValid), .rData(rData), .rId(rId), .rLast(rLast), .rReady(rReady),
    .bValid(bValid), .bId(bId), .bReady(bReady),
    .interrupt(interrupt)
  );

  always #20 CLK = ~CLK;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] nextRandom();
    stimState = xorshift(stimState);
    return stimState;
  endfunction

  // Expected R data for one beat
  function automatic logic [31:0] refRead(input logic [6:0] page, input logic sel,
                                          input logic [4:0] offs, input logic pend,
                                          input logic [31:0] word);
    if (page == 0) begin
      case (offs)
        `CTRL_IRQ_OFFS, `CTRL_IRQ2_OFFS: return {31'b0, pend && !sel};
        `CTRL_ONE_OFFS:  return 32'd1;
        `CTRL_KIND_OFFS: return sel ? `KIND_IND : `KIND_REQ;
        `CTRL_TWO_OFFS:  return 32'd2;
        default:         return 32'd0;
      endcase
    end
    if (offs == `USER_VAL_OFFS) return pend ? word : 32'd0;
    if (offs == `USER_RDY_OFFS) return {31'b0, !pend};  // One while empty
    return 32'd0;
  endfunction

  task automatic stopRun();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("[ERROR] %0t %s got %h expected %h", $time, name, got, want);
      stopRun();
    end
  endtask

  task automatic checkInterrupt();
    @(negedge CLK);
    checkValue("interrupt", interrupt, modelPend && modelIen);
    @(posedge CLK);
    #1;
  endtask

  task automatic readBurst(input logic [6:0] page, input logic sel, input logic [4:0] offs,
                           input logic [3:0] len, input logic [11:0] id);
    logic [4:0] o;
    int i;
    o = offs;
    for (i = 0; i <= len; i++) begin
      expData.push_back(refRead(page, sel, o, modelPend, modelWord));
      expRId.push_back({6'b0, id[5:0]});
      expLast.push_back(i == len);
      if (page != 0 && o == `USER_VAL_OFFS) modelPend = 1'b0;  // Read clears the indication
      o = o + 5'd4;
    end
    arAddr = {19'b0, sel, page, offs};
    arId = id;
    arLen = len;
    arValid = 1'b1;
    @(negedge CLK);
    while (!arReady) @(negedge CLK);
    @(posedge CLK);
    #1;
    arValid = 1'b0;
    while (expData.size() != 0) @(posedge CLK);
    #1;
  endtask

  task automatic writeBurst(input logic [6:0] page, input logic sel, input logic [4:0] offs,
                            input logic [3:0] len, input logic [11:0] id,
                            input logic [31:0] firstWord);
    logic [4:0] o;
    logic [31:0] word;
    int i;
    expBId.push_back({6'b0, id[5:0]});
    awAddr = {19'b0, sel, page, offs};
    awId = id;
    awLen = len;
    awValid = 1'b1;
    @(negedge CLK);
    while (!awReady) @(negedge CLK);
    @(posedge CLK);
    #1;
    awValid = 1'b0;
    o = offs;
    for (i = 0; i <= len; i++) begin
      word = (i == 0) ? firstWord : nextRandom();
      if (page == 0 && o == `CTRL_IEN_OFFS) begin
        modelIen = word[0];
      end else if (page != 0 && !sel) begin
        modelPend = 1'b1;
        modelWord = word;
      end
      wData = word;
      wValid = 1'b1;
      @(negedge CLK);
      while (!wReady) @(negedge CLK);
      @(posedge CLK);
      #1;
      wValid = 1'b0;
      o = o + 5'd4;
    end
    while (expBId.size() != 0) @(posedge CLK);
    #1;
  endtask

  task automatic randomTraffic(input int count);
    logic [31:0] r;
    logic [6:0] page;
    int k;
    for (k = 0; k < count; k++) begin
      r = nextRandom();
      page = r[0] ? 7'd0 : {r[6:1], 1'b1};
      if (r[30]) begin
        readBurst(page, r[8], {r[13:11], 2'b00}, r[17:14], r[29:18]);
      end else if (page == 0 || r[8] || modelPend) begin
        writeBurst(page, page == 0 ? r[8] : 1'b1, {r[13:11], 2'b00}, r[17:14], r[29:18],
                   nextRandom());
      end else begin
        writeBurst(page, 1'b0, {r[13:11], 2'b00}, 4'd0, r[29:18], nextRandom());  // One word
      end
      checkInterrupt();
    end
  endtask

  // Ready stretches for back-pressure
  always @(posedge CLK) begin
    #1;
    if (!pressure) begin
      rReady = 1'b1;
      bReady = 1'b1;
    end else if (holdLeft != 0) begin
      holdLeft = holdLeft - 1'b1;
    end else begin
      readyState = xorshift(readyState);
      rReady = readyState[0];
      bReady = readyState[1];
      holdLeft = readyState[6:4];
    end
  end

  always @(negedge CLK) begin
    if (rValid && rReady) begin
      if (expData.size() == 0) begin
        $display("R beat arrived at %0t with no read outstanding", $time);
        stopRun();
      end else begin
        checkValue("rData", rData, expData.pop_front());
        checkValue("rId", rId, expRId.pop_front());
        checkValue("rLast", rLast, expLast.pop_front());
      end
    end
    if (bValid && bReady) begin
      if (expBId.size() == 0) begin
        $display("B response arrived at %0t with no write outstanding", $time);
        stopRun();
      end else begin
        checkValue("bId", bId, expBId.pop_front());
      end
    end
  end

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles == TimeoutCycles) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      stopRun();
    end
  end

  initial begin
    CLK = 1'b0;
    nRST = 1'b0;
    arValid = 1'b0;
    arAddr = '0;
    arId = '0;
    arLen = '0;
    awValid = 1'b0;
    awAddr = '0;
    awId = '0;
    awLen = '0;
    wValid = 1'b0;
    wData = '0;
    rReady = 1'b1;
    bReady = 1'b1;
    pressure = 1'b0;
    holdLeft = '0;
    stimState = 32'h676d_3564;
    readyState = 32'h676d_3564;
    modelPend = 1'b0;
    modelIen = 1'b0;
    modelWord = '0;
    cycles = 0;
    repeat (8) @(posedge CLK);
    #1;
    nRST = 1'b1;
    checkValue("arReady", arReady, 1);
    checkValue("awReady", awReady, 1);
    checkValue("wReady", wReady, 1);
    checkValue("rValid", rValid, 0);
    checkValue("bValid", bValid, 0);
    checkValue("interrupt", interrupt, 0);

    readBurst(7'd0, 1'b0, 5'd0, 4'd7, 12'h123);  // Whole control page
    readBurst(7'd0, 1'b1, 5'd0, 4'd7, 12'hfc5);
    readBurst(7'd9, 1'b1, 5'd4, 4'd0, 12'h011);
    writeBurst(7'd9, 1'b0, 5'd0, 4'd0, 12'h022, nextRandom());
    checkInterrupt();
    readBurst(7'd9, 1'b1, 5'd4, 4'd0, 12'h033);
    readBurst(7'd0, 1'b0, 5'd0, 4'd7, 12'h044);
    readBurst(7'd0, 1'b1, 5'd0, 4'd7, 12'h055);

    writeBurst(7'd0, 1'b0, 5'd4, 4'd0, 12'h066, 32'h0000_0001);
    checkInterrupt();
    readBurst(7'd9, 1'b1, 5'd0, 4'd1, 12'h077);  // Word, then empty flag
    checkInterrupt();
    writeBurst(7'd9, 1'b0, 5'd8, 4'd0, 12'h088, nextRandom());
    checkInterrupt();
    writeBurst(7'd0, 1'b0, 5'd4, 4'd0, 12'h099, 32'hffff_fffe);  // Reserved bits ignored
    checkInterrupt();
    readBurst(7'd9, 1'b1, 5'd0, 4'd0, 12'h0aa);
    checkInterrupt();
    writeBurst(7'd9, 1'b1, 5'd0, 4'd3, 12'h0bb, nextRandom());  // Dropped
    readBurst(7'd9, 1'b1, 5'd4, 4'd0, 12'h0cc);

    randomTraffic(20);
    pressure = 1'b1;
    randomTraffic(20);
    pressure = 1'b0;

    $display("Regression passed");
    $finish;
  end

endmodule

// File: Bender.yml
package:
  name: portal_bridge

export_include_dirs:
  - logic

sources:
  - logic/portalPkg.sv
  - logic/stageFifo.sv
  - logic/burstSplitter.sv
  - logic/portalControl.sv
  - logic/echoUser.sv
  - logic/portalBridge.sv
  - target: simulation
    files:
      - sim/portalBridgeTb.sv

// File: portalBridge.f
+incdir+logic
logic/portalPkg.sv
logic/stageFifo.sv
logic/burstSplitter.sv
logic/portalControl.sv
logic/echoUser.sv
logic/portalBridge.sv
sim/portalBridgeTb.sv
